// File: verilog.f
+incdir+logic
logic/bus_pkg.sv
logic/addr_decode.sv
logic/dual_ram16.sv
logic/io_ports.sv
logic/vdp_cmd.sv
logic/bus_response.sv
logic/main_cpu_bus.sv
dv/main_cpu_bus_tb.sv

// File: dv/main_cpu_bus_tb.sv
// testbench for the main CPU bus that plays the 68000 and models the program ROM and the VDP
`timescale 1ns/1ps
`include "bus_defines.svh"

module main_cpu_bus_tb;

    // about 200 bus cycles at up to 25 clocks each come to 5000 clocks
    localparam int                 TIMEOUT_CYCLES = 20000;
    localparam bus_pkg::bus_word_t VDP_DOUT       = 16'hC35A;

    logic                  CLK96;
    logic                  RESET96;
    bus_pkg::bus_addr_t    addr;
    bus_pkg::bus_word_t    cpu_dout;
    logic                  rw;
    logic                  as_n;
    logic                  uds_n;
    logic                  lds_n;
    logic                  dtack_n;
    bus_pkg::bus_word_t    cpu_din;
    logic                  prg_cs;
    logic [`PRG_AW-1:0]    prg_addr;
    bus_pkg::bus_word_t    prg_data;
    logic                  prg_ok;
    logic                  op_select_reg;
    logic                  op_write_reg;
    logic                  op_write_ram;
    logic                  op_read_ram_h;
    logic                  op_read_ram_l;
    logic                  op_set_ram_ptr;
    bus_pkg::bus_word_t    vdp_dout;
    logic                  vdp_ack;
    logic [`PALRAM_AW-1:0] pal_addr;
    bus_pkg::bus_word_t    pal_data;
    logic [6:0]            joy1;
    logic [6:0]            joy2;
    logic [6:0]            joy3;
    logic [6:0]            joy4;
    logic [1:0]            start;
    logic [1:0]            coin;
    logic                  service;
    logic                  dip_test;
    logic [7:0]            dipsw_a;
    logic [7:0]            dipsw_b;
    logic [7:0]            dipsw_c;
    logic                  oki_bank;

    integer             seed;
    int                 cycle_count = 0;
    logic [3:0]         rom_delay;     // prg_ok wait for the next ROM access
    logic [3:0]         rom_wait;
    logic [3:0]         vdp_delay;     // ack wait for the next VDP command
    logic [3:0]         vdp_wait;
    logic [5:0]         ops;
    logic [5:0]         ops_at_dtack;
    logic               ack_at_dtack;
    bus_pkg::bus_word_t last_din;
    bus_pkg::bus_word_t wram_model [2**`WRAM_AW];
    bus_pkg::bus_word_t pal_model [2**`PALRAM_AW];

    assign ops = {op_select_reg, op_write_reg, op_write_ram,
                  op_read_ram_h, op_read_ram_l, op_set_ram_ptr};

    main_cpu_bus main_cpu_bus_i (
        .CLK96(CLK96), .RESET96(RESET96), .addr(addr), .cpu_dout(cpu_dout), .rw(rw),
        .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n), .dtack_n(dtack_n), .cpu_din(cpu_din),
        .prg_cs(prg_cs), .prg_addr(prg_addr), .prg_data(prg_data), .prg_ok(prg_ok),
        .op_select_reg(op_select_reg), .op_write_reg(op_write_reg),
        .op_write_ram(op_write_ram), .op_read_ram_h(op_read_ram_h),
        .op_read_ram_l(op_read_ram_l), .op_set_ram_ptr(op_set_ram_ptr),
        .vdp_dout(vdp_dout), .vdp_ack(vdp_ack), .pal_addr(pal_addr), .pal_data(pal_data),
        .joy1(joy1), .joy2(joy2), .joy3(joy3), .joy4(joy4), .start(start), .coin(coin),
        .service(service), .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .dipsw_c(dipsw_c), .oki_bank(oki_bank)
    );

    always #2 CLK96 = ~CLK96;  // 4 ns period

    always @(posedge CLK96) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, a bus cycle never ended", cycle_count);
            stop_with_error();
        end
    end

    // ROM answers after rom_delay cycles of prg_cs
    always @(negedge CLK96) begin
        if (!prg_cs) begin
            prg_ok   <= 1'b0;
            rom_wait <= rom_delay;
        end else if (rom_wait == 4'd0) begin
            prg_ok   <= 1'b1;
            prg_data <= rom_word(prg_addr);
        end else begin
            rom_wait <= rom_wait - 4'd1;
        end
    end

    // VDP acks a pending command after vdp_delay cycles
    always @(negedge CLK96) begin
        if (ops == 6'b000000) begin
            vdp_ack  <= 1'b0;
            vdp_wait <= vdp_delay;
        end else if (vdp_wait == 4'd0) begin
            vdp_ack <= 1'b1;
        end else begin
            vdp_wait <= vdp_wait - 4'd1;
        end
    end

    // ROM contents depend on every address bit
    function automatic bus_pkg::bus_word_t rom_word(input logic [`PRG_AW-1:0] a);
        return {a[7:0], a[15:8]} ^ {a[18:16], 13'h1C35};
    endfunction

    function automatic logic [7:0] player_expect(input logic [6:0] j, input logic p34);
        logic [7:0] b;
        b    = 8'h00;
        b[5] = ~j[5];
        b[4] = ~j[4];
        b[3] = ~j[0];
        b[2] = ~j[1];
        b[1] = ~j[2];
        b[0] = ~j[3];
        if (p34) begin
            b[6] = ~j[6];
        end
        return b;
    endfunction

    function automatic bus_pkg::bus_word_t io_expect(input logic [11:0] off);
        logic [7:0] b;
        b = 8'h00;
        case (off)
            `IO_JMPR: b = dipsw_c;
            `IO_DSWA: b = dipsw_a;
            `IO_DSWB: b = dipsw_b;
            `IO_IN1:  b = player_expect(joy1, 1'b0);
            `IO_IN2:  b = player_expect(joy2, 1'b0);
            `IO_IN3:  b = player_expect(joy3, 1'b1);
            `IO_IN4:  b = player_expect(joy4, 1'b1);
            `IO_SYS: begin
                b[6] = ~start[1];
                b[5] = ~start[0];
                b[4] = ~coin[1];
                b[3] = ~coin[0];
                b[2] = ~dip_test;
                b[0] = ~service;
            end
            default: b = 8'h00;
        endcase
        return {b, b};
    endfunction

    task automatic stop_with_error;
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string name, input bus_pkg::bus_word_t got,
                              input bus_pkg::bus_word_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic check_addr(input string name, input bus_pkg::bus_addr_t got,
                              input bus_pkg::bus_addr_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_with_error();
        end
    endtask

    // wait for DTACK, release as_n, then wait for DTACK to go away
    task automatic finish_cycle;
        @(negedge CLK96);
        while (dtack_n) @(negedge CLK96);
        ops_at_dtack = ops;
        ack_at_dtack = vdp_ack;
        last_din     = cpu_din;
        as_n         = 1'b1;
        while (!dtack_n) @(negedge CLK96);
        rw    = 1'b1;  // data and address stay until the next cycle
        uds_n = 1'b1;
        lds_n = 1'b1;
    endtask

    task automatic cpu_write(input logic [23:0] byte_addr, input bus_pkg::bus_word_t data,
                             input logic [1:0] be);
        @(negedge CLK96);
        addr     = byte_addr[23:1];
        cpu_dout = data;
        rw       = 1'b0;
        uds_n    = ~be[1];
        lds_n    = ~be[0];
        as_n     = 1'b0;
        finish_cycle();
    endtask

    task automatic cpu_read(input logic [23:0] byte_addr, output bus_pkg::bus_word_t data);
        @(negedge CLK96);
        addr  = byte_addr[23:1];
        rw    = 1'b1;
        uds_n = 1'b0;
        lds_n = 1'b0;
        as_n  = 1'b0;
        finish_cycle();
        data = last_din;
    endtask

    task automatic idle_after_reset;
        @(negedge CLK96);
        check_bit("dtack_n", dtack_n, 1'b1);
        check_bit("prg_cs", prg_cs, 1'b0);
        check_bit("vdp strobes", |ops, 1'b0);
        check_bit("oki_bank", oki_bank, 1'b0);
    endtask

    task automatic wram_readback;
        logic [`WRAM_AW-1:0] wa [24];
        bus_pkg::bus_word_t  d;
        logic [1:0]          be;
        for (int i = 0; i < 24; i++) begin
            wa[i] = $random(seed);
            d     = $random(seed);
            cpu_write({8'h10, wa[i], 1'b0}, d, 2'b11);
            wram_model[wa[i]] = d;
        end
        for (int i = 0; i < 24; i++) begin
            be = ($random(seed) & 1) ? 2'b10 : 2'b01;  // one byte lane only
            d  = $random(seed);
            cpu_write({8'h10, wa[i], 1'b0}, d, be);
            if (be[1]) begin
                wram_model[wa[i]][15:8] = d[15:8];
            end
            if (be[0]) begin
                wram_model[wa[i]][7:0] = d[7:0];
            end
        end
        for (int i = 0; i < 24; i++) begin
            cpu_read({8'h10, wa[i], 1'b0}, d);
            check_word("cpu_din", d, wram_model[wa[i]]);
        end
    endtask

    task automatic palette_both_ports;
        logic [`PALRAM_AW-1:0] pa [16];
        bus_pkg::bus_word_t    d;
        for (int i = 0; i < 16; i++) begin
            pa[i] = $random(seed);
            d     = $random(seed);
            cpu_write({12'h400, pa[i], 1'b0}, d, 2'b11);
            pal_model[pa[i]] = d;
        end
        for (int i = 0; i < 16; i++) begin
            cpu_read({12'h400, pa[i], 1'b0}, d);
            check_word("cpu_din", d, pal_model[pa[i]]);
        end
        for (int i = 0; i < 16; i++) begin
            @(negedge CLK96);
            pal_addr = pa[i];
            @(negedge CLK96);  // one cycle of read latency
            check_word("pal_data", pal_data, pal_model[pa[i]]);
        end
    endtask

    task automatic rom_reads;
        logic [17:0]        wa;
        bus_pkg::bus_word_t d;
        for (int i = 0; i < 24; i++) begin
            wa        = $random(seed);
            rom_delay = $random(seed);
            cpu_read({5'h00, wa, 1'b0}, d);
            check_word("cpu_din", d, rom_word({1'b0, wa}));
            check_addr("prg_addr", {4'h0, prg_addr}, {5'h00, wa});
        end
    endtask

    task automatic cabinet_ports;
        logic [11:0]        off;
        bus_pkg::bus_word_t d;
        for (int r = 0; r < 4; r++) begin
            @(negedge CLK96);
            joy1     = $random(seed);
            joy2     = $random(seed);
            joy3     = $random(seed);
            joy4     = $random(seed);
            start    = $random(seed);
            coin     = $random(seed);
            service  = $random(seed);
            dip_test = $random(seed);
            dipsw_a  = $random(seed);
            dipsw_b  = $random(seed);
            dipsw_c  = $random(seed);
            for (int k = 0; k < 9; k++) begin
                off = k * 4;  // 0x020 is unused and reads zero
                cpu_read({12'h700, off}, d);
                check_word("io_data", d, io_expect(off));
            end
        end
        for (int b = 0; b < 2; b++) begin
            d    = $random(seed);
            d[0] = (b == 0);
            cpu_write({12'h700, `IO_OKI_BANK}, d, 2'b11);
            check_bit("oki_bank", oki_bank, d[0]);
        end
    endtask

    task automatic unmapped_read;
        bus_pkg::bus_word_t d;
        cpu_read(24'h500000, d);
        check_word("cpu_din", d, 16'h0000);
    endtask

    // exp holds the strobes from select_reg down to set_ram_ptr
    task automatic vdp_access(input logic [3:0] off, input logic is_read, input logic [5:0] exp);
        bus_pkg::bus_word_t d;
        vdp_delay = $random(seed);
        if (is_read) begin
            cpu_read({20'h30000, off}, d);
            check_word("cpu_din", d, VDP_DOUT);
        end else begin
            d = $random(seed);
            cpu_write({20'h30000, off}, d, 2'b11);
        end
        check_bit("op_select_reg", ops_at_dtack[5], exp[5]);
        check_bit("op_write_reg", ops_at_dtack[4], exp[4]);
        check_bit("op_write_ram", ops_at_dtack[3], exp[3]);
        check_bit("op_read_ram_h", ops_at_dtack[2], exp[2]);
        check_bit("op_read_ram_l", ops_at_dtack[1], exp[1]);
        check_bit("op_set_ram_ptr", ops_at_dtack[0], exp[0]);
        check_bit("vdp_ack", ack_at_dtack, 1'b1);
        while (ops != 6'b000000) @(negedge CLK96);  // strobes drop after the ack
    endtask

    task automatic vdp_strobes;
        vdp_access(`VDP_RAM_PTR, 1'b0, 6'b000001);
        vdp_access(`VDP_RAM_H, 1'b0, 6'b001000);
        vdp_access(`VDP_RAM_L, 1'b0, 6'b001000);
        vdp_access(`VDP_SEL_REG, 1'b0, 6'b100000);
        vdp_access(`VDP_REG, 1'b0, 6'b010000);
        vdp_access(`VDP_RAM_H, 1'b1, 6'b000100);
        vdp_access(`VDP_RAM_L, 1'b1, 6'b000010);
    endtask

    initial begin
        seed      = 32'h48b1;
        CLK96     = 1'b0;
        RESET96   = 1'b1;
        addr      = '0;
        cpu_dout  = '0;
        rw        = 1'b1;
        as_n      = 1'b1;
        uds_n     = 1'b1;
        lds_n     = 1'b1;
        prg_data  = '0;
        prg_ok    = 1'b0;
        rom_delay = 4'd0;
        vdp_delay = 4'd0;
        vdp_dout  = VDP_DOUT;
        vdp_ack   = 1'b0;
        pal_addr  = '0;
        joy1      = '0;
        joy2      = '0;
        joy3      = '0;
        joy4      = '0;
        start     = '0;
        coin      = '0;
        service   = 1'b0;
        dip_test  = 1'b0;
        dipsw_a   = '0;
        dipsw_b   = '0;
        dipsw_c   = '0;
        repeat (2) @(negedge CLK96);
        RESET96 = 1'b0;

        idle_after_reset();
        wram_readback();
        palette_both_ports();
        rom_reads();
        cabinet_ports();
        unmapped_read();
        vdp_strobes();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: logic/main_cpu_bus.sv
// main CPU bus top, decoder, work and palette RAM, cabinet I/O, VDP commands and DTACK
`timescale 1ns/1ps
`include "bus_defines.svh"

module main_cpu_bus (
    input  logic                  CLK96,
    input  logic                  RESET96,
    // CPU side
    input  bus_pkg::bus_addr_t    addr,
    input  bus_pkg::bus_word_t    cpu_dout,
    input  logic                  rw,
    input  logic                  as_n,
    input  logic                  uds_n,
    input  logic                  lds_n,
    output logic                  dtack_n,
    output bus_pkg::bus_word_t    cpu_din,
    // program ROM
    output logic                  prg_cs,
    output logic [`PRG_AW-1:0]    prg_addr,
    input  bus_pkg::bus_word_t    prg_data,
    input  logic                  prg_ok,
    // VDP
    output logic                  op_select_reg,
    output logic                  op_write_reg,
    output logic                  op_write_ram,
    output logic                  op_read_ram_h,
    output logic                  op_read_ram_l,
    output logic                  op_set_ram_ptr,
    input  bus_pkg::bus_word_t    vdp_dout,
    input  logic                  vdp_ack,
    // palette video port
    input  logic [`PALRAM_AW-1:0] pal_addr,
    output bus_pkg::bus_word_t    pal_data,
    // cabinet
    input  logic [6:0]            joy1,
    input  logic [6:0]            joy2,
    input  logic [6:0]            joy3,
    input  logic [6:0]            joy4,
    input  logic [1:0]            start,
    input  logic [1:0]            coin,
    input  logic                  service,
    input  logic                  dip_test,
    input  logic [7:0]            dipsw_a,
    input  logic [7:0]            dipsw_b,
    input  logic [7:0]            dipsw_c,
    output logic                  oki_bank
);

    bus_pkg::bus_region_t region;
    bus_pkg::bus_addr_t   word_addr;
    logic [1:0]           wr_be;
    bus_pkg::bus_word_t   wram_q;
    bus_pkg::bus_word_t   palram_q;
    bus_pkg::bus_word_t   io_data;

    addr_decode addr_decode_i (
        .CLK96(CLK96), .RESET96(RESET96), .addr(addr), .rw(rw), .as_n(as_n),
        .uds_n(uds_n), .lds_n(lds_n), .region(region), .word_addr(word_addr),
        .prg_addr(prg_addr), .wr_be(wr_be)
    );

    // 0x100000 work RAM, video port idle
    dual_ram16 #(.ram_aw(`WRAM_AW), .ram_region(bus_pkg::REGION_WRAM)) wram_i (
        .CLK96(CLK96), .region(region), .wr_be(wr_be),
        .cpu_addr(word_addr[`WRAM_AW-1:0]), .cpu_data(cpu_dout), .cpu_q(wram_q),
        .vid_addr('0), .vid_q()
    );

    // 0x400000 palette RAM
    dual_ram16 #(.ram_aw(`PALRAM_AW), .ram_region(bus_pkg::REGION_PALRAM)) palram_i (
        .CLK96(CLK96), .region(region), .wr_be(wr_be),
        .cpu_addr(word_addr[`PALRAM_AW-1:0]), .cpu_data(cpu_dout), .cpu_q(palram_q),
        .vid_addr(pal_addr), .vid_q(pal_data)
    );

    io_ports io_ports_i (
        .CLK96(CLK96), .RESET96(RESET96), .region(region), .word_addr(word_addr),
        .wr_be(wr_be), .cpu_dout(cpu_dout), .joy1(joy1), .joy2(joy2), .joy3(joy3),
        .joy4(joy4), .start(start), .coin(coin), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c), .io_data(io_data),
        .oki_bank(oki_bank)
    );

    vdp_cmd vdp_cmd_i (
        .CLK96(CLK96), .RESET96(RESET96), .region(region), .word_addr(word_addr),
        .rw(rw), .vdp_ack(vdp_ack), .op_select_reg(op_select_reg),
        .op_write_reg(op_write_reg), .op_write_ram(op_write_ram),
        .op_read_ram_h(op_read_ram_h), .op_read_ram_l(op_read_ram_l),
        .op_set_ram_ptr(op_set_ram_ptr)
    );

    bus_response bus_response_i (
        .CLK96(CLK96), .RESET96(RESET96), .region(region), .as_n(as_n), .rw(rw),
        .prg_ok(prg_ok), .prg_data(prg_data), .vdp_ack(vdp_ack), .vdp_dout(vdp_dout),
        .wram_q(wram_q), .palram_q(palram_q), .io_data(io_data), .prg_cs(prg_cs),
        .dtack_n(dtack_n), .cpu_din(cpu_din)
    );

endmodule

// File: logic/bus_response.sv
// read data multiplexer and DTACK generation for the main CPU bus
`timescale 1ns/1ps

module bus_response (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  bus_pkg::bus_region_t region,
    input  logic                 as_n,
    input  logic                 rw,
    input  logic                 prg_ok,
    input  bus_pkg::bus_word_t   prg_data,
    input  logic                 vdp_ack,
    input  bus_pkg::bus_word_t   vdp_dout,
    input  bus_pkg::bus_word_t   wram_q,
    input  bus_pkg::bus_word_t   palram_q,
    input  bus_pkg::bus_word_t   io_data,
    output logic                 prg_cs,
    output logic                 dtack_n,
    output bus_pkg::bus_word_t   cpu_din
);

    logic [1:0] wait_cnt;  // edges since as_n was sampled low, saturates at 2
    logic       ready;

    assign prg_cs = (region == bus_pkg::REGION_ROM);

    always_comb begin
        case (region)
            bus_pkg::REGION_ROM: ready = prg_ok;
            bus_pkg::REGION_VDP: ready = vdp_ack;
            default:             ready = 1'b1;  // local memories and unmapped
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            wait_cnt <= 2'd0;
            dtack_n  <= 1'b1;
        end else if (as_n) begin
            wait_cnt <= 2'd0;
            dtack_n  <= 1'b1;
        end else begin
            if (wait_cnt != 2'd2) begin
                wait_cnt <= wait_cnt + 2'd1;
            end
            if (wait_cnt == 2'd2 && ready) begin
                dtack_n <= 1'b0;  // held until as_n rises
            end
        end
    end

    // read word frozen once dtack_n is low
    always_ff @(posedge CLK96) begin
        if (dtack_n) begin
            if (!rw) begin
                cpu_din <= '0;
            end else begin
                case (region)
                    bus_pkg::REGION_ROM:    cpu_din <= prg_data;
                    bus_pkg::REGION_WRAM:   cpu_din <= wram_q;
                    bus_pkg::REGION_VDP:    cpu_din <= vdp_dout;
                    bus_pkg::REGION_PALRAM: cpu_din <= palram_q;
                    bus_pkg::REGION_IO:     cpu_din <= io_data;
                    default:                cpu_din <= '0;
                endcase
            end
        end
    end

endmodule

// File: logic/vdp_cmd.sv
// VDP command strobes, set by register offset and held until the VDP acknowledges
`timescale 1ns/1ps
`include "bus_defines.svh"

module vdp_cmd (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  bus_pkg::bus_region_t region,
    input  bus_pkg::bus_addr_t   word_addr,
    input  logic                 rw,
    input  logic                 vdp_ack,
    output logic                 op_select_reg,
    output logic                 op_write_reg,
    output logic                 op_write_ram,
    output logic                 op_read_ram_h,
    output logic                 op_read_ram_l,
    output logic                 op_set_ram_ptr
);

    logic [3:0] offset;
    logic       any_op;
    logic       ack_seen;  // ack came while the access was still running

    assign offset = {word_addr[2:0], 1'b0};
    assign any_op = op_select_reg | op_write_reg | op_write_ram |
                    op_read_ram_h | op_read_ram_l | op_set_ram_ptr;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            op_select_reg  <= 1'b0;
            op_write_reg   <= 1'b0;
            op_write_ram   <= 1'b0;
            op_read_ram_h  <= 1'b0;
            op_read_ram_l  <= 1'b0;
            op_set_ram_ptr <= 1'b0;
            ack_seen       <= 1'b0;
        end else if (region == bus_pkg::REGION_VDP) begin
            if (rw) begin
                case (offset)
                    `VDP_RAM_H: op_read_ram_h <= 1'b1;
                    `VDP_RAM_L: op_read_ram_l <= 1'b1;
                    default:    ;
                endcase
            end else begin
                case (offset)
                    `VDP_RAM_PTR:          op_set_ram_ptr <= 1'b1;
                    `VDP_RAM_H, `VDP_RAM_L: op_write_ram  <= 1'b1;  // either half
                    `VDP_SEL_REG:          op_select_reg  <= 1'b1;
                    `VDP_REG:              op_write_reg   <= 1'b1;
                    default:               ;
                endcase
            end
            ack_seen <= ack_seen | (vdp_ack & any_op);
        end else if (ack_seen || vdp_ack) begin
            // access over, drop everything
            op_select_reg  <= 1'b0;
            op_write_reg   <= 1'b0;
            op_write_ram   <= 1'b0;
            op_read_ram_h  <= 1'b0;
            op_read_ram_l  <= 1'b0;
            op_set_ram_ptr <= 1'b0;
            ack_seen       <= 1'b0;
        end
    end

endmodule

// File: logic/io_ports.sv
// cabinet I/O ports, formats player, system and DIP bytes and holds the OKI bank bit
`timescale 1ns/1ps
`include "bus_defines.svh"

module io_ports (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  bus_pkg::bus_region_t region,
    input  bus_pkg::bus_addr_t   word_addr,
    input  logic [1:0]           wr_be,
    input  bus_pkg::bus_word_t   cpu_dout,
    input  logic [6:0]           joy1,
    input  logic [6:0]           joy2,
    input  logic [6:0]           joy3,
    input  logic [6:0]           joy4,
    input  logic [1:0]           start,
    input  logic [1:0]           coin,
    input  logic                 service,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [7:0]           dipsw_c,
    output bus_pkg::bus_word_t   io_data,
    output logic                 oki_bank
);

    logic [11:0] offset;
    logic [7:0]  sys_byte;

    // inputs are low active on the cabinet side
    function automatic logic [7:0] player_byte(input logic [6:0] joy, input logic has_b6);
        player_byte = {1'b0, has_b6 & ~joy[6], ~joy[5], ~joy[4],
                       ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign offset   = {word_addr[10:0], 1'b0};
    assign sys_byte = {1'b0, ~start[1], ~start[0], ~coin[1], ~coin[0],
                       ~dip_test, 1'b0, ~service};

    // each byte shows up on both halves of the word
    always_comb begin
        case (offset)
            `IO_JMPR: io_data = {2{dipsw_c}};
            `IO_DSWA: io_data = {2{dipsw_a}};
            `IO_DSWB: io_data = {2{dipsw_b}};
            `IO_IN1:  io_data = {2{player_byte(joy1, 1'b0)}};
            `IO_IN2:  io_data = {2{player_byte(joy2, 1'b0)}};
            `IO_IN3:  io_data = {2{player_byte(joy3, 1'b1)}};  // players 3 and 4 have a bit 6
            `IO_IN4:  io_data = {2{player_byte(joy4, 1'b1)}};
            `IO_SYS:  io_data = {2{sys_byte}};
            default:  io_data = '0;
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            oki_bank <= 1'b0;
        end else if (region == bus_pkg::REGION_IO && offset == `IO_OKI_BANK && |wr_be) begin
            oki_bank <= cpu_dout[0];  // sample bank select
        end
    end

endmodule

// File: logic/dual_ram16.sv
// dual-port 16-bit RAM with byte writes from the CPU port and a read-only second port
`timescale 1ns/1ps

module dual_ram16 #(
    parameter int                   ram_aw     = 11,
    parameter bus_pkg::bus_region_t ram_region = bus_pkg::REGION_WRAM
) (
    input  logic                 CLK96,
    input  bus_pkg::bus_region_t region,
    input  logic [1:0]           wr_be,
    input  logic [ram_aw-1:0]    cpu_addr,
    input  bus_pkg::bus_word_t   cpu_data,
    output bus_pkg::bus_word_t   cpu_q,
    input  logic [ram_aw-1:0]    vid_addr,
    output bus_pkg::bus_word_t   vid_q
);

    bus_pkg::bus_word_t mem [2**ram_aw];
    logic               sel;

    assign sel = (region == ram_region);

    // CPU port, byte lanes written separately
    always_ff @(posedge CLK96) begin
        if (sel && wr_be[1]) begin
            mem[cpu_addr][15:8] <= cpu_data[15:8];
        end
        if (sel && wr_be[0]) begin
            mem[cpu_addr][7:0] <= cpu_data[7:0];
        end
        cpu_q <= mem[cpu_addr];
    end

    // second port for video fetch
    always_ff @(posedge CLK96) begin
        vid_q <= mem[vid_addr];
    end

endmodule

// File: logic/addr_decode.sv
// address decoder, registers the region, word address and byte write strobes per access
`timescale 1ns/1ps
`include "bus_defines.svh"

module addr_decode (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  bus_pkg::bus_addr_t   addr,
    input  logic                 rw,
    input  logic                 as_n,
    input  logic                 uds_n,
    input  logic                 lds_n,
    output bus_pkg::bus_region_t region,
    output bus_pkg::bus_addr_t   word_addr,
    output logic [`PRG_AW-1:0]   prg_addr,
    output logic [1:0]           wr_be
);

    logic [23:0]          byte_addr;
    bus_pkg::bus_region_t region_d;

    assign byte_addr = {addr, 1'b0};  // map below is in byte addresses

    always_comb begin
        if (byte_addr <= `ROM_TOP) begin
            region_d = bus_pkg::REGION_ROM;
        end else if (byte_addr[23:16] == `WRAM_BASE) begin
            region_d = bus_pkg::REGION_WRAM;
        end else if (byte_addr[23:20] == `VDP_BASE) begin
            region_d = bus_pkg::REGION_VDP;
        end else if (byte_addr[23:20] == `PALRAM_BASE) begin
            region_d = bus_pkg::REGION_PALRAM;
        end else if (byte_addr[23:12] == `IO_BASE) begin
            region_d = bus_pkg::REGION_IO;
        end else begin
            region_d = bus_pkg::REGION_NONE;  // unmapped
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            region <= bus_pkg::REGION_NONE;
            wr_be  <= 2'b00;
        end else if (!as_n) begin
            region <= region_d;
            wr_be  <= rw ? 2'b00 : {~uds_n, ~lds_n};  // upper, lower byte
        end else begin
            region <= bus_pkg::REGION_NONE;
            wr_be  <= 2'b00;
        end
    end

    always_ff @(posedge CLK96) begin
        if (!as_n) begin
            word_addr <= addr;
            prg_addr  <= addr[`PRG_AW-1:0];  // ROM is word addressed
        end
    end

endmodule

// File: logic/bus_pkg.sv
// shared data, address and region types of the main CPU bus
`include "bus_defines.svh"

package bus_pkg;

    // one data word on the CPU bus
    typedef logic [`BUS_DW-1:0] bus_word_t;

    // word address, no byte bit 0
    typedef logic [`BUS_AW-1:0] bus_addr_t;

    // decoded target of the current access
    typedef enum logic [2:0] {
        REGION_NONE   = 3'd0,  // idle or unmapped
        REGION_ROM    = 3'd1,
        REGION_WRAM   = 3'd2,
        REGION_VDP    = 3'd3,
        REGION_PALRAM = 3'd4,
        REGION_IO     = 3'd5
    } bus_region_t;

endpackage

// File: logic/bus_defines.svh
// address map, bus widths and register offsets of the main CPU bus
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

`define BUS_AW 23           // word address, byte bits 23..1
`define BUS_DW 16

// memory map, compared against byte address bits
`define ROM_TOP     24'h07FFFF
`define WRAM_BASE   8'h10   // bits 23..16
`define VDP_BASE    4'h3    // bits 23..20
`define PALRAM_BASE 4'h4    // bits 23..20
`define IO_BASE     12'h700 // bits 23..12

`define WRAM_AW   15
`define PALRAM_AW 11
`define PRG_AW    19

// cabinet ports, byte offset inside the I/O page
`define IO_JMPR     12'h000
`define IO_DSWA     12'h004
`define IO_DSWB     12'h008
`define IO_IN1      12'h00C
`define IO_IN2      12'h010
`define IO_IN3      12'h014
`define IO_IN4      12'h018
`define IO_SYS      12'h01C
`define IO_OKI_BANK 12'h030

// VDP register offsets
`define VDP_RAM_PTR 4'h0
`define VDP_RAM_H   4'h4
`define VDP_RAM_L   4'h6
`define VDP_SEL_REG 4'h8
`define VDP_REG     4'hC

`endif
